//--- hw/rom_pkg.sv
// shared sizes, offsets and word types for the rom fetch subsystem, referenced as rom_pkg::name
package rom_pkg;

    // slot arrangement
    localparam int SLOT_N  = 3;                   // client slots sharing the memory
    localparam int SLOT_IW = $clog2(SLOT_N);      // bits needed to name one slot

    // memory side
    localparam int WORD_W = 32;                   // one memory word
    localparam int MEM_AW = 22;                   // word address
    localparam int AXI_AW = MEM_AW + 2;           // byte address on the AXI4-Lite bus

    // client data widths
    localparam int SLOT0_DW = 8;                  // byte client
    localparam int SLOT1_DW = 16;                 // halfword client
    localparam int SLOT2_DW = 32;                 // full word client

    // client address widths, counted in units of the client width
    // each one spans 64k memory words
    localparam int SLOT0_AW = 18;
    localparam int SLOT1_AW = 17;
    localparam int SLOT2_AW = 16;

    typedef logic [WORD_W-1:0] mem_word_t;        // word as returned by the memory
    typedef logic [MEM_AW-1:0] mem_addr_t;        // word address into the memory
    typedef logic [SLOT_IW-1:0] slot_idx_t;       // slot number used by the arbiter

    // word offsets of each slot region, 64k words apart so they never overlap
    localparam mem_addr_t SLOT0_OFS = 22'h01_0000;
    localparam mem_addr_t SLOT1_OFS = 22'h02_0000;
    localparam mem_addr_t SLOT2_OFS = 22'h03_0000;

endpackage

//--- hw/slot_bus_if.sv
// request and return path between one rom slot and the shared arbiter
`timescale 1ns/1ps

interface slot_bus_if;

    logic               req;        // slot wants a word, held until rvalid
    rom_pkg::mem_addr_t word_addr;  // stable while req is high
    logic               gnt;        // one cycle, AXI address issued for this slot
    logic               rvalid;     // one cycle, rdata holds the word
    rom_pkg::mem_word_t rdata;      // returned memory word

    // slot side drives the request
    modport slot (
        output req,
        output word_addr,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    // arbiter side answers it
    modport arb (
        input  req,
        input  word_addr,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

//--- hw/rom_slot.sv
// read-only client slot with a two-word cache, instantiated once per client in rom_subsys_top
`timescale 1ns/1ps

module rom_slot #(
    parameter int                 DW  = 8,   // client data width, 8, 16 or 32
    parameter int                 AW  = 18,  // client address width in DW units
    parameter rom_pkg::mem_addr_t OFS = '0   // word offset of this slot's region
) (
    input  logic          clk,
    input  logic          rst,
    // client side
    input  logic [AW-1:0] addr,
    input  logic          addr_ok,
    output logic          data_ok,
    output logic [DW-1:0] dout,
    // memory side
    slot_bus_if.slot      mem
);

    localparam int LANES = rom_pkg::WORD_W / DW;    // client items per memory word
    localparam int LW    = $clog2(LANES);           // lane bits, 0 for a word client
    localparam int LSEL  = (LW > 0) ? LW : 1;       // keeps the lane index at least 1 bit

    logic [LSEL-1:0]    lane;         // lane inside the word, little-endian
    rom_pkg::mem_addr_t waddr;        // memory word address for the current client addr

    // cache, two entries
    logic [1:0]         val;          // entry valid
    rom_pkg::mem_addr_t tag  [2];
    rom_pkg::mem_word_t data [2];
    logic               repl;         // entry taking the next fill
    logic               hit0;
    logic               hit1;
    logic               hit;

    // miss handling
    logic               req_q;
    rom_pkg::mem_addr_t req_addr;     // word being fetched
    logic               wait_rd;      // address went out, word not back yet
    logic               fill;         // returned word accepted this cycle
    logic               fill_ok;      // ...and it is the word the client still wants
    logic               start_miss;

    // answer path
    rom_pkg::mem_word_t word_sel;
    logic               ok_q;         // registered hit or fill
    logic [AW-1:0]      ok_addr;      // client address that ok_q belongs to

    // split the client address into word index and lane
    generate
        if (LW > 0) begin : g_lane
            assign lane = addr[LSEL-1:0];
        end else begin : g_word
            assign lane = '0;         // full word client, one lane only
        end
    endgenerate

    assign waddr = rom_pkg::mem_addr_t'(addr >> LW) + OFS;

    // tag compare against both entries
    assign hit0 = val[0] && (tag[0] == waddr);
    assign hit1 = val[1] && (tag[1] == waddr);
    assign hit  = hit0 | hit1;

    assign fill       = mem.rvalid && wait_rd;
    assign fill_ok    = fill && (req_addr == waddr);
    assign start_miss = addr_ok && !hit && !req_q;

    // fresh data bypasses the cache in the fill cycle
    assign word_sel = fill ? mem.rdata : (hit0 ? data[0] : data[1]);

    assign mem.req       = req_q;
    assign mem.word_addr = req_addr;

    // drops at once when the client moves away or lets go of addr_ok
    assign data_ok = ok_q && addr_ok && (addr == ok_addr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            val     <= '0;
            repl    <= 1'b0;    // first fill lands in entry 0
            req_q   <= 1'b0;
            wait_rd <= 1'b0;
            ok_q    <= 1'b0;
        end else begin
            ok_q <= addr_ok && (hit || fill_ok);
            if (mem.gnt) begin
                wait_rd <= 1'b1;
            end
            if (fill) begin
                // word is in, release the bus and advance the victim
                wait_rd   <= 1'b0;
                req_q     <= 1'b0;
                val[repl] <= 1'b1;
                repl      <= ~repl;
            end else if (start_miss) begin
                req_q <= 1'b1;  // shows on the bus the cycle after addr_ok
            end
        end
    end

    // payload, no reset needed
    always_ff @(posedge clk) begin
        ok_addr <= addr;
        if (start_miss && !fill) begin
            req_addr <= waddr;  // held for the whole fetch
        end
        if (fill) begin
            tag[repl]  <= req_addr;
            data[repl] <= mem.rdata;
        end
        if (addr_ok && (hit || fill_ok)) begin
            dout <= word_sel[lane*DW +: DW];    // lane 0 sits in the low bits
        end
    end

endmodule

//--- hw/slot_arbiter.sv
// round-robin arbiter turning slot misses into single AXI4-Lite reads, one in flight at a time
`timescale 1ns/1ps

module slot_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    // slot side
    slot_bus_if.arb                    slots [rom_pkg::SLOT_N],
    // AXI4-Lite read master
    output logic [rom_pkg::AXI_AW-1:0] araddr,
    output logic                       arvalid,
    input  logic                       arready,
    input  rom_pkg::mem_word_t         rdata,
    input  logic [1:0]                 rresp,   // every response taken as OKAY
    input  logic                       rvalid,
    output logic                       rready
);

    typedef enum logic [1:0] {
        S_IDLE,     // waiting for a request
        S_ADDR,     // arvalid up, waiting for arready
        S_DATA      // rready up, waiting for the word
    } state_t;

    state_t                      state;
    logic [rom_pkg::SLOT_N-1:0]  req_v;      // requests, gathered from the interfaces
    logic [rom_pkg::SLOT_N-1:0]  gnt_v;
    logic [rom_pkg::SLOT_N-1:0]  rv_v;
    logic [rom_pkg::SLOT_N-1:0]  avail;      // requests that can still be served
    rom_pkg::mem_addr_t          addr_v [rom_pkg::SLOT_N];
    rom_pkg::slot_idx_t          cur;        // slot being served, or last one served
    rom_pkg::slot_idx_t          pick;       // next slot in round-robin order
    logic                        found;
    rom_pkg::mem_word_t          rdata_q;

    // interface arrays need constant indices, so flatten them here
    for (genvar i = 0; i < rom_pkg::SLOT_N; i++) begin : g_slot
        assign req_v[i]        = slots[i].req;
        assign addr_v[i]       = slots[i].word_addr;
        assign slots[i].gnt    = gnt_v[i];
        assign slots[i].rvalid = rv_v[i];
        assign slots[i].rdata  = rdata_q;
    end

    // a slot still shows req in its rvalid cycle, keep it out of the pick
    assign avail = req_v & ~rv_v;

    // search starts one past the last served slot
    always_comb begin
        pick  = cur;
        found = 1'b0;
        for (int k = 1; k <= rom_pkg::SLOT_N; k++) begin
            if (!found && avail[(int'(cur) + k) % rom_pkg::SLOT_N]) begin
                pick  = rom_pkg::slot_idx_t'((int'(cur) + k) % rom_pkg::SLOT_N);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            cur   <= rom_pkg::slot_idx_t'(rom_pkg::SLOT_N - 1);    // slot 0 goes first
            gnt_v <= '0;
            rv_v  <= '0;
        end else begin
            gnt_v <= '0;    // both are single cycle strobes
            rv_v  <= '0;
            case (state)
                S_IDLE: begin
                    if (found) begin
                        cur         <= pick;
                        gnt_v[pick] <= 1'b1;    // same cycle arvalid goes up
                        state       <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (arready) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (rvalid) begin
                        rv_v[cur] <= 1'b1;      // only the served slot sees it
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // address and data holding registers
    always_ff @(posedge clk) begin
        if (state == S_IDLE && found) begin
            araddr <= {addr_v[pick], 2'b00};    // word to byte address
        end
        if (state == S_DATA && rvalid) begin
            rdata_q <= rdata;
        end
    end

    assign arvalid = (state == S_ADDR);
    assign rready  = (state == S_DATA);

endmodule

//--- hw/rom_subsys_top.sv
// rom fetch subsystem top, three client slots sharing one AXI4-Lite read port
`timescale 1ns/1ps

module rom_subsys_top (
    input  logic                         clk,
    input  logic                         rst,
    // slot 0, byte client
    input  logic [rom_pkg::SLOT0_AW-1:0] client0_addr,
    input  logic                         client0_addr_ok,
    output logic                         client0_data_ok,
    output logic [rom_pkg::SLOT0_DW-1:0] client0_dout,
    // slot 1, halfword client
    input  logic [rom_pkg::SLOT1_AW-1:0] client1_addr,
    input  logic                         client1_addr_ok,
    output logic                         client1_data_ok,
    output logic [rom_pkg::SLOT1_DW-1:0] client1_dout,
    // slot 2, word client
    input  logic [rom_pkg::SLOT2_AW-1:0] client2_addr,
    input  logic                         client2_addr_ok,
    output logic                         client2_data_ok,
    output logic [rom_pkg::SLOT2_DW-1:0] client2_dout,
    // AXI4-Lite read channels
    output logic [rom_pkg::AXI_AW-1:0]   araddr,
    output logic                         arvalid,
    input  logic                         arready,
    input  logic [rom_pkg::WORD_W-1:0]   rdata,
    input  logic [1:0]                   rresp,
    input  logic                         rvalid,
    output logic                         rready
);

    slot_bus_if bus [rom_pkg::SLOT_N] ();   // one per slot

    rom_slot #(
        .DW  (rom_pkg::SLOT0_DW),
        .AW  (rom_pkg::SLOT0_AW),
        .OFS (rom_pkg::SLOT0_OFS)
    ) u_slot0 (
        .clk     (clk),
        .rst     (rst),
        .addr    (client0_addr),
        .addr_ok (client0_addr_ok),
        .data_ok (client0_data_ok),
        .dout    (client0_dout),
        .mem     (bus[0])
    );

    rom_slot #(
        .DW  (rom_pkg::SLOT1_DW),
        .AW  (rom_pkg::SLOT1_AW),
        .OFS (rom_pkg::SLOT1_OFS)
    ) u_slot1 (
        .clk     (clk),
        .rst     (rst),
        .addr    (client1_addr),
        .addr_ok (client1_addr_ok),
        .data_ok (client1_data_ok),
        .dout    (client1_dout),
        .mem     (bus[1])
    );

    rom_slot #(
        .DW  (rom_pkg::SLOT2_DW),
        .AW  (rom_pkg::SLOT2_AW),
        .OFS (rom_pkg::SLOT2_OFS)
    ) u_slot2 (
        .clk     (clk),
        .rst     (rst),
        .addr    (client2_addr),
        .addr_ok (client2_addr_ok),
        .data_ok (client2_data_ok),
        .dout    (client2_dout),
        .mem     (bus[2])
    );

    slot_arbiter u_arb (
        .clk     (clk),
        .rst     (rst),
        .slots   (bus),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

//--- dv/tb_clk_gen.sv
// testbench clock and reset source, 8 ns period with reset held for the first 4 cycles
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;            // released on the 4th rising edge
    end

    always #4 clk = ~clk;       // 125 MHz

endmodule

//--- dv/tb_mem_pattern.svh
// memory contents for the testbench, included by the AXI memory model and the checker

// upper half is the inverted low address half with the region bits folded in
// lower half is the low address half itself
function automatic rom_pkg::mem_word_t mem_word(input rom_pkg::mem_addr_t a);
    return {~a[15:0] ^ {10'h000, a[21:16]}, a[15:0]};
endfunction

//--- dv/axil_mem_model.sv
// AXI4-Lite read slave for the testbench, answers each read after a random number of cycles
`timescale 1ns/1ps

module axil_mem_model (
    input  logic                       clk,
    input  logic                       rst,
    input  int                         delay_max,   // 0 gives the fastest answers
    input  logic [rom_pkg::AXI_AW-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output rom_pkg::mem_word_t         rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);

    `include "tb_mem_pattern.svh"

    int                          phase;     // 0 address, 1 access, 2 response
    int                          wait_n;
    logic [rom_pkg::AXI_AW-1:0]  addr_q;

    function automatic int pick_delay();
        return (delay_max > 0) ? int'($urandom % (delay_max + 1)) : 0;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= 2'b00;
            phase   <= 0;
            wait_n  <= 0;
        end else begin
            case (phase)
                0: begin
                    if (arvalid && !arready) begin
                        if (wait_n == 0) begin
                            arready <= 1'b1;    // handshake on the next edge
                            addr_q  <= araddr;
                            phase   <= 1;
                            wait_n  <= pick_delay();
                        end else begin
                            wait_n <= wait_n - 1;
                        end
                    end
                end
                1: begin
                    arready <= 1'b0;
                    if (wait_n == 0) begin
                        rvalid <= 1'b1;
                        rdata  <= mem_word(rom_pkg::mem_addr_t'(addr_q >> 2));
                        phase  <= 2;
                    end else begin
                        wait_n <= wait_n - 1;
                    end
                end
                default: begin
                    if (rvalid && rready) begin
                        rvalid <= 1'b0;
                        phase  <= 0;
                        wait_n <= pick_delay();     // arready stall for the next read
                    end
                end
            endcase
        end
    end

endmodule

//--- dv/rom_subsys_checker.sv
// watches the client ports and the AXI read channels, compares dout against the memory pattern
`timescale 1ns/1ps

module rom_subsys_checker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [rom_pkg::SLOT0_AW-1:0] c0_addr,
    input  logic                         c0_data_ok,
    input  logic [rom_pkg::SLOT0_DW-1:0] c0_dout,
    input  logic [rom_pkg::SLOT1_AW-1:0] c1_addr,
    input  logic                         c1_data_ok,
    input  logic [rom_pkg::SLOT1_DW-1:0] c1_dout,
    input  logic [rom_pkg::SLOT2_AW-1:0] c2_addr,
    input  logic                         c2_data_ok,
    input  logic [rom_pkg::SLOT2_DW-1:0] c2_dout,
    input  logic [rom_pkg::AXI_AW-1:0]   araddr,
    input  logic                         arvalid,
    input  logic                         arready,
    input  logic                         rvalid,
    input  logic                         rready
);

    `include "tb_mem_pattern.svh"

    int   err_n = 0;
    int   chk_n = 0;
    int   ar_n  = 0;
    int   ar_hist [0:1023];     // slot served by each AR, in order
    logic rd_pend = 1'b0;       // AR accepted, R not yet taken

    // reference, little-endian lane of the word at (addr / lanes) + region offset
    function automatic logic [31:0] expect_data(input int s, input logic [31:0] a);
        rom_pkg::mem_word_t w;
        case (s)
            0: begin
                w = mem_word(rom_pkg::SLOT0_OFS + rom_pkg::mem_addr_t'(a >> 2));
                return {24'h0, w[a[1:0]*8 +: 8]};
            end
            1: begin
                w = mem_word(rom_pkg::SLOT1_OFS + rom_pkg::mem_addr_t'(a >> 1));
                return {16'h0, w[a[0]*16 +: 16]};
            end
            default: return mem_word(rom_pkg::SLOT2_OFS + rom_pkg::mem_addr_t'(a));
        endcase
    endfunction

    task automatic compare(input int s, input logic [31:0] a, input logic [31:0] got);
        logic [31:0] exp;
        exp = expect_data(s, a);
        chk_n++;
        if (got !== exp) begin
            err_n++;
            $display("ERR @%0t: slot %0d addr %h dout %h expected %h", $time, s, a, got, exp);
        end
    endtask

    // negedge, everything driven on the rising edge has settled
    always @(negedge clk) begin
        if (rst) begin
            rd_pend = 1'b0;
        end else begin
            if (c0_data_ok) compare(0, 32'(c0_addr), 32'(c0_dout));
            if (c1_data_ok) compare(1, 32'(c1_addr), 32'(c1_dout));
            if (c2_data_ok) compare(2, 32'(c2_addr), 32'(c2_dout));
            // rready spans exactly the wait between the AR and R handshakes
            if (rready !== rd_pend) begin
                err_n++;
                $display("ERR @%0t: rready %b, expected %b", $time, rready, rd_pend);
            end
            if (arvalid && arready) begin
                if (ar_n < 1024) ar_hist[ar_n] = int'(araddr >> 18) - 1;   // region to slot
                ar_n++;
                rd_pend = 1'b1;
            end
            if (rvalid && rready) rd_pend = 1'b0;
        end
    end

endmodule

//--- dv/rom_subsys_asserts.sv
// handshake assertions bound into the slot arbiter
`timescale 1ns/1ps

module rom_subsys_asserts (
    input logic                        clk,
    input logic                        rst,
    input logic                        arvalid,
    input logic                        arready,
    input logic [rom_pkg::AXI_AW-1:0]  araddr,
    input logic                        rvalid,
    input logic                        rready,
    input logic [rom_pkg::SLOT_N-1:0]  req_v,
    input logic [rom_pkg::SLOT_N-1:0]  rv_v
);

    int fail_n = 0;     // read by the testbench at the end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
        fail_n++;
        $error("arvalid dropped or araddr moved before arready");
    end

    // one slot answered per R handshake, in the cycle right after it
    a_one_rv: assert property (@(posedge clk) disable iff (rst)
        $onehot0(rv_v) && ((|rv_v) == $past(rvalid && rready)))
    else begin
        fail_n++;
        $error("rvalid not sent to exactly one slot after an R handshake");
    end

    a_rv_req: assert property (@(posedge clk) disable iff (rst) (rv_v & ~req_v) == '0)
    else begin
        fail_n++;
        $error("rvalid sent to a slot with req low");
    end

endmodule

bind slot_arbiter rom_subsys_asserts u_asserts (
    .clk     (clk),
    .rst     (rst),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .req_v   (req_v),
    .rv_v    (rv_v)
);

//--- dv/rom_subsys_tb.sv
// testbench top for the rom fetch subsystem, runs the client read scenarios and prints the result
`timescale 1ns/1ps

module rom_subsys_tb;

    localparam int TIMEOUT = 200;   // cycles allowed per data_ok wait

    logic clk, rst;
    logic [rom_pkg::SLOT0_AW-1:0] c0_addr;
    logic [rom_pkg::SLOT1_AW-1:0] c1_addr;
    logic [rom_pkg::SLOT2_AW-1:0] c2_addr;
    logic [2:0]                   addr_ok;
    wire  [2:0]                   dok;
    logic [rom_pkg::SLOT0_DW-1:0] c0_dout;
    logic [rom_pkg::SLOT1_DW-1:0] c1_dout;
    logic [rom_pkg::SLOT2_DW-1:0] c2_dout;
    logic [rom_pkg::AXI_AW-1:0]   araddr;
    logic                         arvalid, arready, rvalid, rready;
    rom_pkg::mem_word_t           rdata;
    logic [1:0]                   rresp;
    int                           delay_max;
    int                           tb_fail;

    tb_clk_gen u_clk (.clk(clk), .rst(rst));

    rom_subsys_top DUT (
        .clk(clk), .rst(rst),
        .client0_addr(c0_addr), .client0_addr_ok(addr_ok[0]),
        .client0_data_ok(dok[0]), .client0_dout(c0_dout),
        .client1_addr(c1_addr), .client1_addr_ok(addr_ok[1]),
        .client1_data_ok(dok[1]), .client1_dout(c1_dout),
        .client2_addr(c2_addr), .client2_addr_ok(addr_ok[2]),
        .client2_data_ok(dok[2]), .client2_dout(c2_dout),
        .araddr(araddr), .arvalid(arvalid), .arready(arready), .rdata(rdata),
        .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    axil_mem_model u_mem (
        .clk(clk), .rst(rst), .delay_max(delay_max),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    rom_subsys_checker chk (
        .clk(clk), .rst(rst),
        .c0_addr(c0_addr), .c0_data_ok(dok[0]), .c0_dout(c0_dout),
        .c1_addr(c1_addr), .c1_data_ok(dok[1]), .c1_dout(c1_dout),
        .c2_addr(c2_addr), .c2_data_ok(dok[2]), .c2_dout(c2_dout),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rready(rready)
    );

    function automatic int total_errs();
        return tb_fail + chk.err_n + DUT.u_arb.u_asserts.fail_n;
    endfunction

    // client address of a lane inside a slot word, lane bits at the bottom
    function automatic logic [31:0] client_addr(input int s, input int word, input int lane);
        return (s == 0) ? (word << 2) | lane : (s == 1) ? (word << 1) | lane : word;
    endfunction

    task automatic set_client(input int s, input logic [31:0] a, input logic ok);
        case (s)
            0: c0_addr <= a[rom_pkg::SLOT0_AW-1:0];
            1: c1_addr <= a[rom_pkg::SLOT1_AW-1:0];
            default: c2_addr <= a[rom_pkg::SLOT2_AW-1:0];
        endcase
        addr_ok[s] <= ok;
    endtask

    // lat counts rising edges from addr_ok to a visible data_ok
    task automatic wait_data(input int s, output int lat);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!dok[s] && n < TIMEOUT);
        if (!dok[s]) begin
            tb_fail++;
            $display("slot %0d never raised data_ok, gave up waiting at %0t", s, $time);
        end
        lat = n - 1;
    endtask

    task automatic read_one(input int s, input int word, input int lane,
                            input int exp_ars, input bit chk_lat);
        int ar0, lat;
        ar0 = chk.ar_n;
        @(posedge clk);
        set_client(s, client_addr(s, word, lane), 1'b1);
        wait_data(s, lat);
        if (exp_ars >= 0 && chk.ar_n - ar0 != exp_ars) begin
            tb_fail++;
            $display("ERR @%0t: slot %0d word %h caused %0d AR, expected %0d",
                     $time, s, word, chk.ar_n - ar0, exp_ars);
        end
        if (chk_lat && lat != 1) begin
            tb_fail++;
            $display("ERR @%0t: slot %0d hit took %0d cycles, expected 1", $time, s, lat);
        end
        @(posedge clk);
        addr_ok[s] <= 1'b0;     // one idle cycle between accesses
    endtask

    task automatic report(input int n, input string name, input int errs0);
        $display("test %0d %s: %s", n, name, (total_errs() == errs0) ? "ok" : "failed");
    endtask

    initial begin
        int e0, n, lat, last, base;
        void'($urandom(32'h411b));
        c0_addr = '0;
        c1_addr = '0;
        c2_addr = '0;
        addr_ok = '0;
        delay_max = 0;
        tb_fail = 0;
        n = 0;
        @(posedge clk);
        while (rst && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst) begin
            tb_fail++;
            $display("reset never released");
        end

        e0 = total_errs();
        for (int s = 0; s < 3; s++) read_one(s, 5, 0, 1, 1'b0);
        report(1, "cold miss per slot", e0);

        e0 = total_errs();
        for (int l = 1; l < 4; l++) read_one(0, 5, l, 0, 1'b1);
        read_one(1, 5, 1, 0, 1'b1);
        read_one(2, 5, 0, 0, 1'b1);
        report(2, "hits within a word", e0);

        // A=0x100, B=0x101, C=0x102 on slot 0
        e0 = total_errs();
        read_one(0, 'h100, 0, 1, 1'b0);
        read_one(0, 'h101, 0, 1, 1'b0);
        read_one(0, 'h100, 1, 0, 1'b1);
        read_one(0, 'h102, 0, 1, 1'b0);     // C evicts A
        read_one(0, 'h101, 2, 0, 1'b1);
        read_one(0, 'h100, 3, 1, 1'b0);
        report(3, "alternating replacement", e0);

        e0 = total_errs();
        last = chk.ar_hist[chk.ar_n - 1];
        base = chk.ar_n;
        @(posedge clk);
        for (int s = 0; s < 3; s++) set_client(s, client_addr(s, 'h300 + s, 0), 1'b1);
        for (int s = 0; s < 3; s++) wait_data(s, lat);
        @(posedge clk);
        addr_ok <= '0;
        if (chk.ar_n - base != 3) begin
            tb_fail++;
            $display("ERR @%0t: three simultaneous misses caused %0d AR, expected 3",
                     $time, chk.ar_n - base);
        end
        for (int k = 0; k < 3; k++) begin
            if (chk.ar_hist[base + k] != (last + 1 + k) % 3) begin
                tb_fail++;
                $display("ERR @%0t: AR %0d served slot %0d, expected slot %0d",
                         $time, k, chk.ar_hist[base + k], (last + 1 + k) % 3);
            end
        end
        report(4, "simultaneous misses", e0);

        e0 = total_errs();
        delay_max = 6;
        for (int i = 0; i < 200; i++) begin
            n = int'($urandom % 3);
            read_one(n, int'($urandom % 48), int'($urandom % (4 >> n)), -1, 1'b0);
        end
        delay_max = 0;
        report(5, "random reads under delays", e0);

        e0 = total_errs();
        for (int l = 0; l < 4; l++) read_one(0, 'h200, l, (l == 0) ? 1 : 0, 1'b0);
        for (int l = 0; l < 2; l++) read_one(1, 'h201, l, (l == 0) ? 1 : 0, 1'b0);
        report(6, "lane selection", e0);

        $display("tests 6, checks %0d, ARs %0d, errors %0d", chk.chk_n, chk.ar_n, total_errs());
        if (total_errs() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
hw/rom_pkg.sv
hw/slot_bus_if.sv
hw/rom_slot.sv
hw/slot_arbiter.sv
hw/rom_subsys_top.sv
+incdir+dv
dv/tb_clk_gen.sv
dv/axil_mem_model.sv
dv/rom_subsys_checker.sv
dv/rom_subsys_asserts.sv
dv/rom_subsys_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rom_subsys_tb
FLIST     = tb.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# exit status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
